/* design/lane.sv */
// Vector lane top level

`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module lane import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Instruction port
  input  logic     req_valid_i,
  input  lane_op_e req_op_i,
  input  vid_t     req_id_i,
  input  vreg_t    req_vs1_i,
  input  vreg_t    req_vs2_i,
  input  vreg_t    req_vd_i,
  input  vlen_t    req_vl_i,
  output logic     req_ready_o,
  output logic     done_o,
  output vid_t     done_id_o,
  // Load port
  input  logic     ldu_req_i,
  input  vaddr_t   ldu_addr_i,
  input  elen_t    ldu_wdata_i,
  output logic     ldu_gnt_o,
  // Store port
  output elen_t    stu_operand_o,
  output logic     stu_operand_valid_o,
  input  logic     stu_operand_ready_i
);

  logic                          rd_start;
  vreg_t                         rd_vs1;
  vreg_t                         rd_vs2;
  vlen_t                         rd_vl;
  logic                          rd_store;
  logic                          alu_start;
  lane_op_e                      alu_op;
  vreg_t                         alu_vd;
  vlen_t                         alu_vl;
  logic                          alu_done;
  logic                          wb_valid;
  wb_req_t                       wb_req;
  logic                          wb_gnt;
  logic     [`LANE_NR_BANKS-1:0] bank_req;
  logic     [`LANE_NR_BANKS-1:0] bank_we;
  brow_t    [`LANE_NR_BANKS-1:0] bank_addr;
  elen_t    [`LANE_NR_BANKS-1:0] bank_wdata;
  opqueue_e [`LANE_NR_BANKS-1:0] bank_tgt;
  elen_t    [2:0]                vrf_operand;
  logic     [2:0]                vrf_operand_valid;
  elen_t    [2:0]                q_data;
  logic     [2:0]                q_valid;
  logic     [2:0]                q_pop;
  qcnt_t    [2:0]                q_free;
  logic                          a_pop;
  logic                          b_pop;

  //////////////////////////////
  // Control
  //////////////////////////////

  lane_sequencer i_sequencer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_valid_i(req_valid_i),
    .req_op_i   (req_op_i),
    .req_id_i   (req_id_i),
    .req_vs1_i  (req_vs1_i),
    .req_vs2_i  (req_vs2_i),
    .req_vd_i   (req_vd_i),
    .req_vl_i   (req_vl_i),
    .req_ready_o(req_ready_o),
    .done_o     (done_o),
    .done_id_o  (done_id_o),
    .alu_done_i (alu_done),
    .stu_valid_i(q_valid[STU]),
    .stu_ready_i(stu_operand_ready_i),
    .rd_start_o (rd_start),
    .rd_vs1_o   (rd_vs1),
    .rd_vs2_o   (rd_vs2),
    .rd_vl_o    (rd_vl),
    .rd_store_o (rd_store),
    .alu_start_o(alu_start),
    .alu_op_o   (alu_op),
    .alu_vd_o   (alu_vd),
    .alu_vl_o   (alu_vl)
  );

  operand_requester i_requester (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_start_i  (rd_start),
    .rd_vs1_i    (rd_vs1),
    .rd_vs2_i    (rd_vs2),
    .rd_vl_i     (rd_vl),
    .rd_store_i  (rd_store),
    .wb_valid_i  (wb_valid),
    .wb_req_i    (wb_req),
    .wb_gnt_o    (wb_gnt),
    .ldu_req_i   (ldu_req_i),
    .ldu_addr_i  (ldu_addr_i),
    .ldu_wdata_i (ldu_wdata_i),
    .ldu_gnt_o   (ldu_gnt_o),
    .q_free_i    (q_free),
    .bank_req_o  (bank_req),
    .bank_we_o   (bank_we),
    .bank_addr_o (bank_addr),
    .bank_wdata_o(bank_wdata),
    .bank_tgt_o  (bank_tgt)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  vector_regfile i_vrf (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (bank_req),
    .we_i           (bank_we),
    .addr_i         (bank_addr),
    .wdata_i        (bank_wdata),
    .tgt_i          (bank_tgt),
    .operand_o      (vrf_operand),
    .operand_valid_o(vrf_operand_valid)
  );

  always_comb begin
    q_pop        = '0;
    q_pop[ALU_A] = a_pop;
    q_pop[ALU_B] = b_pop;
    q_pop[STU]   = stu_operand_ready_i;
  end

  // Queues indexed by opqueue_e
  for (genvar q = 0; q < 3; q++) begin : gen_opq
    operand_queue #(
      .T    (elen_t),
      .Depth(`LANE_QUEUE_DEPTH)
    ) i_opq (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .push_i (vrf_operand_valid[q]),
      .data_i (vrf_operand[q]),
      .pop_i  (q_pop[q]),
      .data_o (q_data[q]),
      .valid_o(q_valid[q]),
      .free_o (q_free[q])
    );
  end

  valu i_valu (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .alu_start_i(alu_start),
    .alu_op_i   (alu_op),
    .alu_vd_i   (alu_vd),
    .alu_vl_i   (alu_vl),
    .alu_done_o (alu_done),
    .a_i        (q_data[ALU_A]),
    .a_valid_i  (q_valid[ALU_A]),
    .a_pop_o    (a_pop),
    .b_i        (q_data[ALU_B]),
    .b_valid_i  (q_valid[ALU_B]),
    .b_pop_o    (b_pop),
    .wb_valid_o (wb_valid),
    .wb_req_o   (wb_req),
    .wb_gnt_i   (wb_gnt)
  );

  // Store queue head goes straight out
  assign stu_operand_o       = q_data[STU];
  assign stu_operand_valid_o = q_valid[STU];

endmodule

`default_nettype wire

/* design/lane_consts.svh */
// Lane sizing constants

`ifndef LANE_CONSTS_SVH
`define LANE_CONSTS_SVH

// Datapath width of one element
`define LANE_ELEN 32

// Architectural vector registers
`define LANE_NR_VREGS 32

// Elements held per register in this lane
`define LANE_MAX_VL 8

// Register file banks, selected by the low address bits
`define LANE_NR_BANKS 4

// Entries in each operand queue and in the result buffer
`define LANE_QUEUE_DEPTH 4

// Instruction tag width
`define LANE_ID_WIDTH 3

`endif

/* design/lane_pkg.sv */
// Lane types

`default_nettype none

`include "lane_consts.svh"

package lane_pkg;

  typedef logic [`LANE_ELEN-1:0]                  elen_t;
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0]       vreg_t;
  typedef logic [$clog2(`LANE_MAX_VL+1)-1:0]       vlen_t;
  typedef logic [$clog2(`LANE_MAX_VL)-1:0]         eidx_t;
  // Register number in the upper bits, element index in the lower ones
  typedef logic [$clog2(`LANE_NR_VREGS*`LANE_MAX_VL)-1:0] vaddr_t;
  typedef logic [$clog2(`LANE_NR_BANKS)-1:0]       bank_t;
  // Row inside one bank
  typedef logic [$clog2(`LANE_NR_VREGS*`LANE_MAX_VL/`LANE_NR_BANKS)-1:0] brow_t;
  typedef logic [$clog2(`LANE_QUEUE_DEPTH+1)-1:0]  qcnt_t;
  typedef logic [`LANE_ID_WIDTH-1:0]               vid_t;

  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VAND   = 3'd2,
    VOR    = 3'd3,
    VXOR   = 3'd4,
    VSTORE = 3'd5
  } lane_op_e;

  typedef enum logic [1:0] {
    ALU_A = 2'd0,
    ALU_B = 2'd1,
    STU   = 2'd2
  } opqueue_e;

  typedef struct packed {
    vaddr_t addr;
    elen_t  wdata;
  } wb_req_t;

endpackage

`default_nettype wire

/* design/lane_sequencer.sv */
// Lane sequencer

`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module lane_sequencer import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Instruction port
  input  logic     req_valid_i,
  input  lane_op_e req_op_i,
  input  vid_t     req_id_i,
  input  vreg_t    req_vs1_i,
  input  vreg_t    req_vs2_i,
  input  vreg_t    req_vd_i,
  input  vlen_t    req_vl_i,
  output logic     req_ready_o,
  output logic     done_o,
  output vid_t     done_id_o,
  // Completion sources
  input  logic     alu_done_i,
  input  logic     stu_valid_i,
  input  logic     stu_ready_i,
  // Read command
  output logic     rd_start_o,
  output vreg_t    rd_vs1_o,
  output vreg_t    rd_vs2_o,
  output vlen_t    rd_vl_o,
  output logic     rd_store_o,
  // ALU command
  output logic     alu_start_o,
  output lane_op_e alu_op_o,
  output vreg_t    alu_vd_o,
  output vlen_t    alu_vl_o
);

  logic     busy_q;
  logic     done_q;
  logic     rd_start_q;
  logic     alu_start_q;
  lane_op_e op_q;
  vid_t     id_q;
  vreg_t    vs1_q;
  vreg_t    vs2_q;
  vreg_t    vd_q;
  vlen_t    vl_q;
  vlen_t    st_cnt_q;
  logic     is_store;
  logic     finish;

  assign req_ready_o = !busy_q;
  assign is_store    = (op_q == VSTORE);

  // A store ends once every element has left through the store port
  assign finish = busy_q && !done_q && (is_store ? (st_cnt_q == vl_q) : alu_done_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      rd_start_q  <= 1'b0;
      alu_start_q <= 1'b0;
      op_q        <= VADD;
      id_q        <= '0;
      vs1_q       <= '0;
      vs2_q       <= '0;
      vd_q        <= '0;
      vl_q        <= '0;
      st_cnt_q    <= '0;
    end else begin
      rd_start_q  <= 1'b0;
      alu_start_q <= 1'b0;
      done_q      <= finish;
      if (req_valid_i && req_ready_o) begin
        busy_q      <= 1'b1;
        rd_start_q  <= 1'b1;
        alu_start_q <= (req_op_i != VSTORE);
        op_q        <= req_op_i;
        id_q        <= req_id_i;
        vs1_q       <= req_vs1_i;
        vs2_q       <= req_vs2_i;
        vd_q        <= req_vd_i;
        vl_q        <= req_vl_i;
        st_cnt_q    <= '0;
      end else if (done_q) begin
        // Ready comes back the cycle after the done pulse
        busy_q <= 1'b0;
      end
      if (busy_q && is_store && stu_valid_i && stu_ready_i) begin
        st_cnt_q <= st_cnt_q + vlen_t'(1);
      end
    end
  end

  assign done_o      = done_q;
  assign done_id_o   = id_q;
  assign rd_start_o  = rd_start_q;
  assign rd_vs1_o    = vs1_q;
  assign rd_vs2_o    = vs2_q;
  assign rd_vl_o     = vl_q;
  assign rd_store_o  = is_store;
  assign alu_start_o = alu_start_q;
  assign alu_op_o    = op_q;
  assign alu_vd_o    = vd_q;
  assign alu_vl_o    = vl_q;

endmodule

`default_nettype wire

/* design/operand_queue.sv */
// Operand FIFO

`timescale 1ns/1ps
`default_nettype none

module operand_queue import lane_pkg::*; #(
  parameter type         T     = elen_t,
  parameter int unsigned Depth = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  T                           data_i,
  input  logic                       pop_i,
  output T                           data_o,
  output logic                       valid_o,
  output logic [$clog2(Depth+1)-1:0] free_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth+1);

  T                mem [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            do_push;
  logic            do_pop;

  assign valid_o = (cnt_q != '0);
  assign data_o  = mem[rd_ptr_q];
  assign free_o  = CntW'(Depth) - cnt_q;

  assign do_pop  = pop_i && valid_o;
  // A full queue still takes an element when one leaves in the same cycle
  assign do_push = push_i && ((cnt_q != CntW'(Depth)) || do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

endmodule

`default_nettype wire

/* design/operand_requester.sv */
// Operand requester and bank arbiter

`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module operand_requester import lane_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Read command from the sequencer
  input  logic                          rd_start_i,
  input  vreg_t                         rd_vs1_i,
  input  vreg_t                         rd_vs2_i,
  input  vlen_t                         rd_vl_i,
  input  logic                          rd_store_i,
  // ALU writeback
  input  logic                          wb_valid_i,
  input  wb_req_t                       wb_req_i,
  output logic                          wb_gnt_o,
  // Load port
  input  logic                          ldu_req_i,
  input  vaddr_t                        ldu_addr_i,
  input  elen_t                         ldu_wdata_i,
  output logic                          ldu_gnt_o,
  // Free entries per operand queue
  input  qcnt_t    [2:0]                q_free_i,
  // Bank requests
  output logic     [`LANE_NR_BANKS-1:0] bank_req_o,
  output logic     [`LANE_NR_BANKS-1:0] bank_we_o,
  output brow_t    [`LANE_NR_BANKS-1:0] bank_addr_o,
  output elen_t    [`LANE_NR_BANKS-1:0] bank_wdata_o,
  output opqueue_e [`LANE_NR_BANKS-1:0] bank_tgt_o
);

  vreg_t                     vs1_q;
  vreg_t                     vs2_q;
  vlen_t                     vl_q;
  logic                      store_q;
  vlen_t                     cnt1_q;
  vlen_t                     cnt2_q;
  logic [2:0]                issued_q;
  logic [2:0]                issued_d;
  vaddr_t                    addr1;
  vaddr_t                    addr2;
  bank_t                     bank1;
  bank_t                     bank2;
  bank_t                     wb_bank;
  bank_t                     ld_bank;
  opqueue_e                  tgt2;
  logic                      need1;
  logic                      need2;
  logic                      rd1_go;
  logic                      rd2_go;
  logic [`LANE_NR_BANKS-1:0] wr_busy;

  //////////////////////////////
  // Element addresses
  //////////////////////////////

  assign addr1 = {vs1_q, eidx_t'(cnt1_q)};
  assign addr2 = {vs2_q, eidx_t'(cnt2_q)};

  // Bank is the address modulo the bank count
  assign bank1   = bank_t'(addr1);
  assign bank2   = bank_t'(addr2);
  assign wb_bank = bank_t'(wb_req_i.addr);
  assign ld_bank = bank_t'(ldu_addr_i);

  // A store only reads vs2, into the store queue
  assign tgt2  = store_q ? STU : ALU_B;
  assign need1 = !store_q && (cnt1_q < vl_q);
  assign need2 = (cnt2_q < vl_q);

  //////////////////////////////
  // Fixed priority arbitration
  //////////////////////////////

  assign wb_gnt_o  = wb_valid_i;
  assign ldu_gnt_o = ldu_req_i && !(wb_valid_i && (wb_bank == ld_bank));

  always_comb begin
    wr_busy = '0;
    if (wb_valid_i) begin
      wr_busy[wb_bank] = 1'b1;
    end
    if (ldu_gnt_o) begin
      wr_busy[ld_bank] = 1'b1;
    end
  end

  // Reads issued last cycle land in their queue this cycle
  assign rd1_go = need1 && !wr_busy[bank1] &&
                  (q_free_i[ALU_A] > qcnt_t'(issued_q[ALU_A]));
  assign rd2_go = need2 && !wr_busy[bank2] && !(rd1_go && (bank1 == bank2)) &&
                  (q_free_i[tgt2] > qcnt_t'(issued_q[tgt2]));

  always_comb begin
    issued_d        = '0;
    issued_d[ALU_A] = rd1_go;
    issued_d[tgt2]  = rd2_go;
  end

  always_comb begin
    for (int b = 0; b < `LANE_NR_BANKS; b++) begin
      bank_req_o[b]   = 1'b0;
      bank_we_o[b]    = 1'b0;
      bank_addr_o[b]  = '0;
      bank_wdata_o[b] = '0;
      bank_tgt_o[b]   = ALU_A;
      if (wb_valid_i && (wb_bank == bank_t'(b))) begin
        bank_req_o[b]   = 1'b1;
        bank_we_o[b]    = 1'b1;
        bank_addr_o[b]  = brow_t'(wb_req_i.addr >> $bits(bank_t));
        bank_wdata_o[b] = wb_req_i.wdata;
      end else if (ldu_gnt_o && (ld_bank == bank_t'(b))) begin
        bank_req_o[b]   = 1'b1;
        bank_we_o[b]    = 1'b1;
        bank_addr_o[b]  = brow_t'(ldu_addr_i >> $bits(bank_t));
        bank_wdata_o[b] = ldu_wdata_i;
      end else if (rd1_go && (bank1 == bank_t'(b))) begin
        bank_req_o[b]  = 1'b1;
        bank_addr_o[b] = brow_t'(addr1 >> $bits(bank_t));
        bank_tgt_o[b]  = ALU_A;
      end else if (rd2_go && (bank2 == bank_t'(b))) begin
        bank_req_o[b]  = 1'b1;
        bank_addr_o[b] = brow_t'(addr2 >> $bits(bank_t));
        bank_tgt_o[b]  = tgt2;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vs1_q    <= '0;
      vs2_q    <= '0;
      vl_q     <= '0;
      store_q  <= 1'b0;
      cnt1_q   <= '0;
      cnt2_q   <= '0;
      issued_q <= '0;
    end else begin
      issued_q <= issued_d;
      if (rd_start_i) begin
        vs1_q   <= rd_vs1_i;
        vs2_q   <= rd_vs2_i;
        vl_q    <= rd_vl_i;
        store_q <= rd_store_i;
        cnt1_q  <= '0;
        cnt2_q  <= '0;
      end else begin
        cnt1_q <= cnt1_q + vlen_t'(rd1_go);
        cnt2_q <= cnt2_q + vlen_t'(rd2_go);
      end
    end
  end

endmodule

`default_nettype wire

/* design/valu.sv */
// Vector integer ALU

`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module valu import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Command
  input  logic     alu_start_i,
  input  lane_op_e alu_op_i,
  input  vreg_t    alu_vd_i,
  input  vlen_t    alu_vl_i,
  output logic     alu_done_o,
  // Operands, a from vs1 and b from vs2
  input  elen_t    a_i,
  input  logic     a_valid_i,
  output logic     a_pop_o,
  input  elen_t    b_i,
  input  logic     b_valid_i,
  output logic     b_pop_o,
  // Writeback
  output logic     wb_valid_o,
  output wb_req_t  wb_req_o,
  input  logic     wb_gnt_i
);

  logic     active_q;
  lane_op_e op_q;
  vreg_t    vd_q;
  vlen_t    vl_q;
  vlen_t    idx_q;
  vlen_t    gnt_cnt_q;
  qcnt_t    res_free;
  logic     pop;
  elen_t    result;
  wb_req_t  res_req;

  // Pop both operands together, only with room in the result buffer
  assign pop = active_q && a_valid_i && b_valid_i && (res_free != '0) && (idx_q < vl_q);
  assign a_pop_o = pop;
  assign b_pop_o = pop;

  always_comb begin
    unique case (op_q)
      VADD:    result = b_i + a_i;
      VSUB:    result = b_i - a_i;
      VAND:    result = b_i & a_i;
      VOR:     result = b_i | a_i;
      VXOR:    result = b_i ^ a_i;
      default: result = b_i;
    endcase
  end

  assign res_req.addr  = {vd_q, eidx_t'(idx_q)};
  assign res_req.wdata = result;

  operand_queue #(
    .T    (wb_req_t),
    .Depth(`LANE_QUEUE_DEPTH)
  ) i_result_buf (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (pop),
    .data_i (res_req),
    .pop_i  (wb_gnt_i),
    .data_o (wb_req_o),
    .valid_o(wb_valid_o),
    .free_o (res_free)
  );

  // Last element granted, or nothing to do at all
  assign alu_done_o = active_q &&
                      ((wb_gnt_i && (gnt_cnt_q == vl_q - vlen_t'(1))) || (vl_q == '0));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q  <= 1'b0;
      op_q      <= VADD;
      vd_q      <= '0;
      vl_q      <= '0;
      idx_q     <= '0;
      gnt_cnt_q <= '0;
    end else if (alu_start_i) begin
      active_q  <= 1'b1;
      op_q      <= alu_op_i;
      vd_q      <= alu_vd_i;
      vl_q      <= alu_vl_i;
      idx_q     <= '0;
      gnt_cnt_q <= '0;
    end else begin
      if (alu_done_o) begin
        active_q <= 1'b0;
      end
      idx_q     <= idx_q + vlen_t'(pop);
      gnt_cnt_q <= gnt_cnt_q + vlen_t'(wb_gnt_i);
    end
  end

endmodule

`default_nettype wire

/* design/vector_regfile.sv */
// Banked vector register file

`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module vector_regfile import lane_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic     [`LANE_NR_BANKS-1:0] req_i,
  input  logic     [`LANE_NR_BANKS-1:0] we_i,
  input  brow_t    [`LANE_NR_BANKS-1:0] addr_i,
  input  elen_t    [`LANE_NR_BANKS-1:0] wdata_i,
  input  opqueue_e [`LANE_NR_BANKS-1:0] tgt_i,
  // One element per operand queue
  output elen_t    [2:0]                operand_o,
  output logic     [2:0]                operand_valid_o
);

  localparam int unsigned NrRows = `LANE_NR_VREGS * `LANE_MAX_VL / `LANE_NR_BANKS;

  elen_t                         mem [`LANE_NR_BANKS][NrRows];
  elen_t    [`LANE_NR_BANKS-1:0] rdata_q;
  logic     [`LANE_NR_BANKS-1:0] rvalid_q;
  opqueue_e [`LANE_NR_BANKS-1:0] rtgt_q;

  // Storage and read data
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `LANE_NR_BANKS; b++) begin
      if (req_i[b] && we_i[b]) begin
        mem[b][addr_i[b]] <= wdata_i[b];
      end
      if (req_i[b] && !we_i[b]) begin
        rdata_q[b] <= mem[b][addr_i[b]];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
      rtgt_q   <= '{default: ALU_A};
    end else begin
      rvalid_q <= req_i & ~we_i;
      rtgt_q   <= tgt_i;
    end
  end

  // Steer each bank's data to the queue named by its tag
  always_comb begin
    operand_o       = '0;
    operand_valid_o = '0;
    for (int b = 0; b < `LANE_NR_BANKS; b++) begin
      if (rvalid_q[b]) begin
        operand_o[rtgt_q[b]]       = rdata_q[b];
        operand_valid_o[rtgt_q[b]] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/lane_pkg.sv
design/operand_queue.sv
design/lane_sequencer.sv
design/operand_requester.sv
design/vector_regfile.sv
design/valu.sv
design/lane.sv
test/tb_lane.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_lane -f files.f -o tb_lane &&
./obj_dir/tb_lane | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* test/tb_lane.sv */
// Lane testbench

`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module tb_lane import lane_pkg::*; ();

  localparam int clk_period     = 100;
  localparam int max_vl         = `LANE_MAX_VL;
  localparam int nr_vregs       = `LANE_NR_VREGS;
  // Watchdog budget from instructions issued and registers loaded
  localparam int nr_instr       = 64;
  localparam int instr_cycles   = 250;
  localparam int nr_load_regs   = 40;
  localparam int load_cycles    = 100;
  localparam int timeout_cycles = nr_instr * instr_cycles + nr_load_regs * load_cycles;

  logic        clk_i;
  logic        rst_ni;
  logic        req_valid_i;
  lane_op_e    req_op_i;
  vid_t        req_id_i;
  vreg_t       req_vs1_i;
  vreg_t       req_vs2_i;
  vreg_t       req_vd_i;
  vlen_t       req_vl_i;
  logic        req_ready_o;
  logic        done_o;
  vid_t        done_id_o;
  logic        ldu_req_i;
  vaddr_t      ldu_addr_i;
  elen_t       ldu_wdata_i;
  logic        ldu_gnt_o;
  elen_t       stu_operand_o;
  logic        stu_operand_valid_o;
  logic        stu_operand_ready_i;

  integer      seed = 59042;
  int          errors;
  int          test_err_base;
  int          tests_passed;
  int          tests_failed;
  vid_t        next_id;
  logic        rand_ready;
  logic [31:0] model [nr_vregs][max_vl];
  logic [31:0] stored [$];
  logic        in_flight;
  vid_t        cur_id;
  int          accept_count;
  int          done_count;
  logic        stall_q;
  logic [31:0] stall_data_q;
  lane_op_e    alu_ops [5];

  lane dut0 (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_valid_i        (req_valid_i),
    .req_op_i           (req_op_i),
    .req_id_i           (req_id_i),
    .req_vs1_i          (req_vs1_i),
    .req_vs2_i          (req_vs2_i),
    .req_vd_i           (req_vd_i),
    .req_vl_i           (req_vl_i),
    .req_ready_o        (req_ready_o),
    .done_o             (done_o),
    .done_id_o          (done_id_o),
    .ldu_req_i          (ldu_req_i),
    .ldu_addr_i         (ldu_addr_i),
    .ldu_wdata_i        (ldu_wdata_i),
    .ldu_gnt_o          (ldu_gnt_o),
    .stu_operand_o      (stu_operand_o),
    .stu_operand_valid_o(stu_operand_valid_o),
    .stu_operand_ready_i(stu_operand_ready_i)
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  // Store port stalls at random while enabled
  always @(negedge clk_i) begin
    if (rand_ready) begin
      stu_operand_ready_i = ($random(seed) % 2) != 0;
    end else begin
      stu_operand_ready_i = 1'b1;
    end
  end

  //////////////////////////////
  // Protocol checks
  //////////////////////////////

  done_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                   !(done_o && req_ready_o))
    else begin
      $display("Ready was high at %0t during a done pulse", $time);
      errors++;
    end

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                  !ldu_gnt_o || ldu_req_i)
    else begin
      $display("Load grant at %0t without a load request", $time);
      errors++;
    end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (in_flight) begin
        assert (!req_ready_o) else begin
          $display("Ready was high at %0t while instruction %0d was running", $time, cur_id);
          errors++;
        end
      end
      if (done_o) begin
        assert (in_flight) else begin
          $display("Done pulse at %0t without an accepted instruction", $time);
          errors++;
        end
        assert (done_id_o == cur_id) else begin
          $display("mismatch at %0t: done ID %0d, expected %0d", $time, done_id_o, cur_id);
          errors++;
        end
        done_count++;
        in_flight = 1'b0;
      end
      if (req_valid_i && req_ready_o) begin
        in_flight = 1'b1;
        cur_id    = req_id_i;
        accept_count++;
      end
      // Stalled element must stay valid and unchanged
      if (stall_q) begin
        assert (stu_operand_valid_o) else begin
          $display("Store valid dropped at %0t before its handshake", $time);
          errors++;
        end
        assert (stu_operand_o == stall_data_q) else begin
          $display("mismatch at %0t: stalled store data changed from %08h to %08h",
                   $time, stall_data_q, stu_operand_o);
          errors++;
        end
      end
      if (stu_operand_valid_o && stu_operand_ready_i) begin
        stored.push_back(stu_operand_o);
      end
      stall_q      = stu_operand_valid_o && !stu_operand_ready_i;
      stall_data_q = stu_operand_o;
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the lane stopped making progress",
             timeout_cycles);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////
  // Reference and stimulus
  //////////////////////////////

  // Result rule with b from vs2 and a from vs1
  function automatic logic [31:0] alu_ref(input lane_op_e op, input logic [31:0] b,
                                          input logic [31:0] a);
    case (op)
      VADD:    return b + a;
      VSUB:    return b - a;
      VAND:    return b & a;
      VOR:     return b | a;
      VXOR:    return b ^ a;
      default: return b;
    endcase
  endfunction

  task automatic start_test();
    test_err_base = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_err_base) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAILED with %0d errors", name, errors - test_err_base);
    end
  endtask

  // Request held until the grant is seen
  task automatic load_reg(input vreg_t vr);
    logic [31:0] data;
    for (int i = 0; i < max_vl; i++) begin
      data = $random(seed);
      @(negedge clk_i);
      ldu_req_i   = 1'b1;
      ldu_addr_i  = {vr, eidx_t'(i)};
      ldu_wdata_i = data;
      do @(posedge clk_i); while (!ldu_gnt_o);
      model[vr][i] = data;
    end
    @(negedge clk_i);
    ldu_req_i = 1'b0;
  endtask

  task automatic issue_instr(input lane_op_e op, input vreg_t vs1, input vreg_t vs2,
                             input vreg_t vd, input vlen_t vl);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_id_i    = next_id;
    req_vs1_i   = vs1;
    req_vs2_i   = vs2;
    req_vd_i    = vd;
    req_vl_i    = vl;
    next_id     = next_id + vid_t'(1);
    do @(posedge clk_i); while (!req_ready_o);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    do @(posedge clk_i); while (!done_o);
    @(negedge clk_i);
  endtask

  task automatic run_alu(input lane_op_e op, input vreg_t vs1, input vreg_t vs2,
                         input vreg_t vd, input vlen_t vl);
    for (int i = 0; i < int'(vl); i++) begin
      model[vd][i] = alu_ref(op, model[vs2][i], model[vs1][i]);
    end
    issue_instr(op, vs1, vs2, vd, vl);
  endtask

  task automatic check_stored(input vreg_t vr, input vlen_t vl);
    assert (stored.size() == int'(vl)) else begin
      $display("mismatch at %0t: v%0d gave %0d stored elements, expected %0d",
               $time, vr, stored.size(), vl);
      errors++;
    end
    for (int i = 0; i < stored.size() && i < int'(vl); i++) begin
      assert (stored[i] == model[vr][i]) else begin
        $display("mismatch at %0t: v%0d[%0d] stored %08h, expected %08h",
                 $time, vr, i, stored[i], model[vr][i]);
        errors++;
      end
    end
  endtask

  task automatic store_and_compare(input vreg_t vr, input vlen_t vl);
    stored.delete();
    issue_instr(VSTORE, '0, vr, '0, vl);
    check_stored(vr, vl);
  endtask

  initial begin : main
    vreg_t vs_a;
    vreg_t vs_b;
    vreg_t bp_regs [3];
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    req_valid_i         = 1'b0;
    req_op_i            = VADD;
    req_id_i            = '0;
    req_vs1_i           = '0;
    req_vs2_i           = '0;
    req_vd_i            = '0;
    req_vl_i            = '0;
    ldu_req_i           = 1'b0;
    ldu_addr_i          = '0;
    ldu_wdata_i         = '0;
    stu_operand_ready_i = 1'b1;
    rand_ready          = 1'b0;
    errors              = 0;
    tests_passed        = 0;
    tests_failed        = 0;
    next_id             = '0;
    in_flight           = 1'b0;
    cur_id              = '0;
    accept_count        = 0;
    done_count          = 0;
    stall_q             = 1'b0;
    stall_data_q        = '0;
    alu_ops             = '{VADD, VSUB, VAND, VOR, VXOR};
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    start_test();
    assert (req_ready_o && !done_o && !stu_operand_valid_o && !ldu_gnt_o) else begin
      $display("mismatch at %0t: outputs after reset ready=%b done=%b valid=%b gnt=%b",
               $time, req_ready_o, done_o, stu_operand_valid_o, ldu_gnt_o);
      errors++;
    end
    finish_test("reset values");

    start_test();
    for (int r = 0; r < nr_vregs; r++) begin
      load_reg(vreg_t'(r));
    end
    for (int r = 0; r < nr_vregs; r++) begin
      store_and_compare(vreg_t'(r), vlen_t'(max_vl));
    end
    finish_test("load then store");

    // Each operation into its own destination
    for (int k = 0; k < 5; k++) begin
      start_test();
      vs_a = vreg_t'({$random(seed)} % 16);
      vs_b = vreg_t'({$random(seed)} % 16);
      run_alu(alu_ops[k], vs_a, vs_b, vreg_t'(16 + k), vlen_t'(max_vl));
      store_and_compare(vreg_t'(16 + k), vlen_t'(max_vl));
      finish_test({"alu ", alu_ops[k].name()});
    end

    start_test();
    for (int n = 0; n < 3; n++) begin
      bp_regs[n] = vreg_t'({$random(seed)} % nr_vregs);
    end
    @(posedge clk_i);
    rand_ready = 1'b1;
    for (int n = 0; n < 3; n++) begin
      store_and_compare(bp_regs[n], vlen_t'(max_vl));
    end
    run_alu(VADD, 5, 6, 23, vlen_t'(max_vl));
    store_and_compare(23, vlen_t'(max_vl));
    @(posedge clk_i);
    rand_ready = 1'b0;
    @(negedge clk_i);
    finish_test("store back-pressure");

    start_test();
    // Load port competes with the writeback
    fork
      run_alu(VADD, 1, 2, 20, vlen_t'(max_vl));
      load_reg(30);
    join
    store_and_compare(20, vlen_t'(max_vl));
    store_and_compare(30, vlen_t'(max_vl));
    run_alu(VXOR, 20, 3, 21, 5);
    store_and_compare(21, vlen_t'(max_vl));
    store_and_compare(21, 5);
    run_alu(VSUB, 21, 20, 22, 1);
    store_and_compare(22, vlen_t'(max_vl));
    store_and_compare(22, 1);
    finish_test("chain and vector length");

    start_test();
    for (int i = 0; i < max_vl; i++) begin
      model[25][i] = alu_ref(VOR, model[5][i], model[4][i]);
    end
    stored.delete();
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_op_i    = VOR;
    req_id_i    = next_id;
    req_vs1_i   = 4;
    req_vs2_i   = 5;
    req_vd_i    = 25;
    req_vl_i    = vlen_t'(max_vl);
    next_id     = next_id + vid_t'(1);
    do @(posedge clk_i); while (!req_ready_o);
    // Next request waits with valid held high
    @(negedge clk_i);
    req_op_i  = VSTORE;
    req_id_i  = next_id;
    req_vs1_i = '0;
    req_vs2_i = 25;
    req_vd_i  = '0;
    next_id   = next_id + vid_t'(1);
    do @(posedge clk_i); while (!req_ready_o);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    do @(posedge clk_i); while (!done_o);
    @(negedge clk_i);
    check_stored(25, vlen_t'(max_vl));
    assert (accept_count == done_count) else begin
      $display("mismatch at %0t: %0d instructions accepted, %0d done pulses",
               $time, accept_count, done_count);
      errors++;
    end
    finish_test("busy");

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
